/* axil_decode.sv */
`timescale 1ns/1ps

module axil_decode import axil_pkg::*, sram_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic [axil_addr_w-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,

  input  logic [axil_data_w-1:0] wdata,
  input  logic [axil_strb_w-1:0] wstrb,
  input  logic                   wvalid,
  output logic                   wready,

  input  logic [axil_addr_w-1:0] araddr,
  input  logic                   arvalid,
  output logic                   arready,

  sram_cmd_if.decode             cmd
);

  logic       wr_pending;
  logic       rd_sel;
  logic       wr_sel;
  logic       cmd_fire;
  logic       last_was_write;
  axil_addr_u addr;

  // a write needs both AW and W
  assign wr_pending = awvalid && wvalid;

  // writes win unless the last one went past a waiting read
  assign rd_sel = arvalid && (!wr_pending || last_was_write);
  assign wr_sel = wr_pending && !rd_sel;

  assign cmd_fire = cmd.valid && cmd.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_was_write <= 1'b0;
    end else if (cmd_fire) begin
      last_was_write <= wr_sel && arvalid;
    end
  end

  assign addr.raw = wr_sel ? awaddr : araddr;

  assign cmd.valid   = wr_sel || rd_sel;
  assign cmd.wr_en   = wr_sel;
  assign cmd.idx     = addr.split.word[sram_idx_w-1:0];
  assign cmd.err     = addr.split.word >= axil_word_w'(sram_depth);
  assign cmd.wr_data = wdata;
  assign cmd.wr_strb = wstrb;

  // AW and W are taken on the same edge
  assign awready = wr_sel && cmd.ready;
  assign wready  = wr_sel && cmd.ready;
  assign arready = rd_sel && cmd.ready;

endmodule

/* axil_pkg.sv */
package axil_pkg;

  localparam int axil_addr_w = 16;
  localparam int axil_data_w = 32;
  localparam int axil_strb_w = axil_data_w / 8;
  localparam int axil_off_w = $clog2(axil_strb_w);
  localparam int axil_word_w = axil_addr_w - axil_off_w;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axil_resp_t;

  // word index above the byte lane
  typedef struct packed {
    logic [axil_word_w-1:0] word;
    logic [axil_off_w-1:0]  offset;
  } axil_split_t;

  // same address bits read raw or split
  typedef union packed {
    logic [axil_addr_w-1:0] raw;
    axil_split_t            split;
  } axil_addr_u;

endpackage

/* axil_result.sv */
`timescale 1ns/1ps

module axil_result import axil_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  sram_rsp_if.result             rsp,

  output axil_resp_t             bresp,
  output logic                   bvalid,
  input  logic                   bready,

  output logic [axil_data_w-1:0] rdata,
  output axil_resp_t             rresp,
  output logic                   rvalid,
  input  logic                   rready
);

  logic b_free;
  logic r_free;
  logic b_load;
  logic r_load;

  // each register frees on its own handshake
  assign b_free = !bvalid || bready;
  assign r_free = !rvalid || rready;

  assign rsp.ready = rsp.is_wr ? b_free : r_free;

  assign b_load = rsp.valid && rsp.ready && rsp.is_wr;
  assign r_load = rsp.valid && rsp.ready && !rsp.is_wr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      bresp  <= resp_okay;
    end else if (b_load) begin
      bvalid <= 1'b1;
      bresp  <= rsp.resp;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // R holds under stall while B keeps moving
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
      rresp  <= resp_okay;
      rdata  <= '0;
    end else if (r_load) begin
      rvalid <= 1'b1;
      rresp  <= rsp.resp;
      rdata  <= rsp.rd_data;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

endmodule

/* axil_sram_top.sv */
`timescale 1ns/1ps

module axil_sram_top import axil_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic [axil_addr_w-1:0] s_axil_awaddr,
  input  logic                   s_axil_awvalid,
  output logic                   s_axil_awready,

  input  logic [axil_data_w-1:0] s_axil_wdata,
  input  logic [axil_strb_w-1:0] s_axil_wstrb,
  input  logic                   s_axil_wvalid,
  output logic                   s_axil_wready,

  output axil_resp_t             s_axil_bresp,
  output logic                   s_axil_bvalid,
  input  logic                   s_axil_bready,

  input  logic [axil_addr_w-1:0] s_axil_araddr,
  input  logic                   s_axil_arvalid,
  output logic                   s_axil_arready,

  output logic [axil_data_w-1:0] s_axil_rdata,
  output axil_resp_t             s_axil_rresp,
  output logic                   s_axil_rvalid,
  input  logic                   s_axil_rready
);

  sram_cmd_if cmd_if ();
  sram_rsp_if rsp_if ();

  axil_decode axil_decode_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (s_axil_awaddr),
    .awvalid (s_axil_awvalid),
    .awready (s_axil_awready),
    .wdata   (s_axil_wdata),
    .wstrb   (s_axil_wstrb),
    .wvalid  (s_axil_wvalid),
    .wready  (s_axil_wready),
    .araddr  (s_axil_araddr),
    .arvalid (s_axil_arvalid),
    .arready (s_axil_arready),
    .cmd     (cmd_if.decode)
  );

  sram_execute sram_execute_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .cmd   (cmd_if.execute),
    .rsp   (rsp_if.execute)
  );

  axil_result axil_result_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .rsp    (rsp_if.result),
    .bresp  (s_axil_bresp),
    .bvalid (s_axil_bvalid),
    .bready (s_axil_bready),
    .rdata  (s_axil_rdata),
    .rresp  (s_axil_rresp),
    .rvalid (s_axil_rvalid),
    .rready (s_axil_rready)
  );

endmodule

/* list.f */
+incdir+.
axil_pkg.sv
sram_pkg.sv
sram_cmd_if.sv
sram_rsp_if.sv
axil_decode.sv
sram_execute.sv
axil_result.sv
axil_sram_top.sv
tb_axil_sram.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f list.f --top-module tb_axil_sram -o sim_axil_sram \
  > build.log 2>&1 &&
  ./obj_dir/sim_axil_sram > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "test passed" sim.log 2>/dev/null && echo "run ok" ||
  { echo "run failed, see build.log and sim.log"; exit 1; }

/* sram_cmd_if.sv */
`timescale 1ns/1ps

interface sram_cmd_if import sram_pkg::*;;

  logic       valid;
  logic       ready;
  logic       wr_en;
  sram_idx_t  idx;
  sram_data_t wr_data;
  sram_strb_t wr_strb;
  // word index past the end of the array
  logic       err;

  modport decode (
    output valid, wr_en, idx, wr_data, wr_strb, err,
    input  ready
  );

  modport execute (
    input  valid, wr_en, idx, wr_data, wr_strb, err,
    output ready
  );

endinterface

/* sram_execute.sv */
`timescale 1ns/1ps

module sram_execute import sram_pkg::*, axil_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  sram_cmd_if.execute cmd,
  sram_rsp_if.execute rsp
);

  sram_data_t mem [sram_depth];

  logic       slot_valid;
  logic       slot_is_wr;
  sram_data_t slot_data;
  axil_resp_t slot_resp;
  logic       cmd_fire;

  // slot frees up in the cycle result takes it
  assign cmd.ready = !slot_valid || rsp.ready;
  assign cmd_fire  = cmd.valid && cmd.ready;

  // strobed write that skips out of range words
  always_ff @(posedge clk) begin
    if (cmd_fire && cmd.wr_en && !cmd.err) begin
      for (int b = 0; b < sram_strb_w; b++) begin
        if (cmd.wr_strb[b]) begin
          mem[cmd.idx][8*b +: 8] <= cmd.wr_data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slot_valid <= 1'b0;
    end else if (cmd_fire) begin
      slot_valid <= 1'b1;
    end else if (rsp.ready) begin
      slot_valid <= 1'b0;
    end
  end

  // read sees the word from before this edge
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      slot_is_wr <= cmd.wr_en;
      slot_data  <= (cmd.wr_en || cmd.err) ? '0 : mem[cmd.idx];
      slot_resp  <= cmd.err ? resp_slverr : resp_okay;
    end
  end

  assign rsp.valid   = slot_valid;
  assign rsp.is_wr   = slot_is_wr;
  assign rsp.rd_data = slot_data;
  assign rsp.resp    = slot_resp;

endmodule

/* sram_pkg.sv */
package sram_pkg;

  localparam int sram_depth = 1024;
  localparam int sram_idx_w = $clog2(sram_depth);
  localparam int sram_data_w = 32;
  localparam int sram_strb_w = sram_data_w / 8;

  // one memory word
  typedef logic [sram_data_w-1:0] sram_data_t;

  // bit n enables byte n
  typedef logic [sram_strb_w-1:0] sram_strb_t;

  typedef logic [sram_idx_w-1:0] sram_idx_t;

endpackage

/* sram_rsp_if.sv */
`timescale 1ns/1ps

interface sram_rsp_if import sram_pkg::*, axil_pkg::*;;

  logic       valid;
  logic       ready;
  // marks a write response for B
  logic       is_wr;
  sram_data_t rd_data;
  axil_resp_t resp;

  modport execute (
    output valid, is_wr, rd_data, resp,
    input  ready
  );

  modport result (
    input  valid, is_wr, rd_data, resp,
    output ready
  );

endinterface

/* tb_axil_sram_checks.svh */
`ifndef TB_AXIL_SRAM_CHECKS_SVH
`define TB_AXIL_SRAM_CHECKS_SVH

string      cur_test;
int         n_checks;
int         n_errors;
int         test_errs;
sram_data_t ref_mem [sram_depth];

// strobed merge in range, SLVERR with no change past the end
function automatic sram_data_t ref_access(input logic wr, input axil_addr_u a,
                                          input sram_data_t d, input sram_strb_t s,
                                          output axil_resp_t resp);
  sram_idx_t idx;
  if (a.split.word >= axil_word_w'(sram_depth)) begin
    resp = resp_slverr;
    return '0;
  end
  idx = a.split.word[sram_idx_w-1:0];
  resp = resp_okay;
  if (wr) begin
    for (int b = 0; b < sram_strb_w; b++) begin
      if (s[b]) ref_mem[idx][8*b +: 8] = d[8*b +: 8];
    end
    return '0;
  end
  return ref_mem[idx];
endfunction

task automatic note_error(input string msg);
  $display("%s: %s", cur_test, msg);
  n_errors++;
  test_errs++;
endtask

task automatic check_resp(input string what, input axil_resp_t exp, input axil_resp_t act);
  n_checks++;
  if (exp !== act) begin
    $display("[FAIL] %s %s expected %b actual %b", cur_test, what, exp, act);
    n_errors++;
    test_errs++;
  end
endtask

task automatic check_data(input string what, input sram_data_t exp, input sram_data_t act);
  n_checks++;
  if (exp !== act) begin
    $display("[FAIL] %s %s expected %h actual %h", cur_test, what, exp, act);
    n_errors++;
    test_errs++;
  end
endtask

`endif

/* tb_axil_sram.sv */
`timescale 1ns/1ps

module tb_axil_sram import axil_pkg::*, sram_pkg::*; ();

  localparam int n_full = 64;
  localparam int n_partial = 24;
  localparam int n_mixed = 100;
  // one AW then W write and four out of range accesses besides the loops
  localparam int n_txn = 1 + 2 * n_full + 2 * n_partial + 4 + n_mixed;

  logic clk, rst_n;
  logic [axil_addr_w-1:0] awaddr, araddr;
  logic awvalid, awready, wvalid, wready, arvalid, arready;
  logic [axil_data_w-1:0] wdata, rdata;
  logic [axil_strb_w-1:0] wstrb;
  axil_resp_t bresp, rresp;
  logic bvalid, bready, rvalid, rready;

  logic [31:0] lfsr_state = 32'h7fc1_3a92;
  logic        rand_ready;
  int          b_seen;
  axil_resp_t  exp_b [$];
  axil_resp_t  exp_r [$];
  sram_data_t  exp_rd [$];

  `include "tb_axil_sram_checks.svh"

  axil_sram_top axil_sram_top_inst (
    .clk(clk), .rst_n(rst_n),
    .s_axil_awaddr(awaddr), .s_axil_awvalid(awvalid), .s_axil_awready(awready),
    .s_axil_wdata(wdata), .s_axil_wstrb(wstrb), .s_axil_wvalid(wvalid),
    .s_axil_wready(wready), .s_axil_bresp(bresp), .s_axil_bvalid(bvalid),
    .s_axil_bready(bready), .s_axil_araddr(araddr), .s_axil_arvalid(arvalid),
    .s_axil_arready(arready), .s_axil_rdata(rdata), .s_axil_rresp(rresp),
    .s_axil_rvalid(rvalid), .s_axil_rready(rready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic axil_addr_u word_addr(input int word);
    axil_addr_u a;
    a.split.word   = axil_word_w'(word);
    a.split.offset = '0;
    return a;
  endfunction

  // each task starts and ends on a falling edge
  task automatic do_write(input axil_addr_u a, input sram_data_t d, input sram_strb_t s);
    axil_resp_t r;
    awaddr = a.raw;
    awvalid = 1'b1;
    wdata = d;
    wstrb = s;
    wvalid = 1'b1;
    #1;
    while (!(awready && wready)) begin
      @(negedge clk);
      #1;
    end
    void'(ref_access(1'b1, a, d, s, r));
    exp_b.push_back(r);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
  endtask

  task automatic do_read(input axil_addr_u a);
    axil_resp_t r;
    araddr = a.raw;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    exp_rd.push_back(ref_access(1'b0, a, '0, '0, r));
    exp_r.push_back(r);
    @(negedge clk);
    arvalid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_b.size() != 0 || exp_r.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  task automatic drain_and_report();
    wait_drained();
    $display("%s: %0d errors", cur_test, test_errs);
    test_errs = 0;
  endtask

  // ready patterns
  initial begin
    logic [31:0] rdy;
    forever begin
      @(negedge clk);
      if (rand_ready) begin
        rdy = take_bits(2);
        bready = rdy[0];
        rready = rdy[1];
      end else begin
        bready = 1'b1;
        rready = 1'b1;
      end
    end
  end

  // compare mid low phase so handshakes are known before the edge
  initial begin
    logic       b_hold, r_hold;
    axil_resp_t b_last, r_last;
    sram_data_t d_last;
    b_hold = 1'b0;
    r_hold = 1'b0;
    forever begin
      @(negedge clk);
      #2;
      if (b_hold && !(bvalid && bresp == b_last))
        note_error("B response changed before its handshake");
      if (r_hold && !(rvalid && rresp == r_last && rdata == d_last))
        note_error("R response changed before its handshake");
      if (bvalid && bready) begin
        b_seen++;
        if (exp_b.size() == 0) note_error("B response arrived with no write outstanding");
        else check_resp("bresp", exp_b.pop_front(), bresp);
      end
      if (rvalid && rready) begin
        if (exp_r.size() == 0) begin
          note_error("R response arrived with no read outstanding");
        end else begin
          check_resp("rresp", exp_r.pop_front(), rresp);
          check_data("rdata", exp_rd.pop_front(), rdata);
        end
      end
      b_hold = bvalid && !bready;
      r_hold = rvalid && !rready;
      b_last = bresp;
      r_last = rresp;
      d_last = rdata;
    end
  end

  initial begin
    repeat (n_txn * 20 + 200) @(posedge clk);
    $display("watchdog: run did not finish in time, %0d B and %0d R responses missing",
             exp_b.size(), exp_r.size());
    $display("test failed");
    $finish;
  end

  initial begin
    int k;
    rst_n = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    bready = 1'b1;
    rready = 1'b1;
    rand_ready = 1'b0;
    for (int i = 0; i < sram_depth; i++) ref_mem[i] = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    cur_test = "reset_and_aw_only";
    #1;
    if (bvalid || rvalid) note_error("BVALID or RVALID high after reset");
    check_resp("bresp after reset", resp_okay, bresp);
    check_resp("rresp after reset", resp_okay, rresp);
    @(negedge clk);
    awaddr = word_addr(3);
    awvalid = 1'b1;
    repeat (5) begin
      #1;
      if (bvalid || awready) note_error("write went ahead without W data");
      @(negedge clk);
    end
    do_write(word_addr(3), 32'h1234_5678, 4'hf);
    wait_drained();
    if (b_seen != 1) note_error("expected exactly one B response for AW then W");
    drain_and_report();

    cur_test = "full_word_readback";
    for (int i = 0; i < n_full; i++) do_write(word_addr(i), sram_data_t'(take_bits(32)), 4'hf);
    for (int i = 0; i < n_full; i++) do_read(word_addr(i));
    drain_and_report();

    cur_test = "partial_strobes";
    for (int i = 0; i < n_partial; i++) begin
      k = int'(take_bits(6));
      do_write(word_addr(k), sram_data_t'(take_bits(32)), sram_strb_t'(take_bits(4)));
      do_read(word_addr(k));
    end
    drain_and_report();

    cur_test = "out_of_range";
    k = int'(take_bits(6));
    do_write(word_addr(sram_depth + k), 32'hdead_beef, 4'hf);
    do_read(word_addr(sram_depth + k));
    do_read(word_addr(k));
    do_read(word_addr(14'h3fff));
    drain_and_report();

    cur_test = "mixed_random_backpressure";
    rand_ready = 1'b1;
    for (int i = 0; i < n_mixed; i++) begin
      k = int'(take_bits(6));
      if (take_bits(1) == 32'd1) begin
        do_write(word_addr(k), sram_data_t'(take_bits(32)), sram_strb_t'(take_bits(4)));
      end else begin
        do_read(word_addr(k));
      end
    end
    drain_and_report();
    rand_ready = 1'b0;

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
